// ==== verilog/mpmc_consts.svh ====
`ifndef MPMC_CONSTS_SVH
`define MPMC_CONSTS_SVH

// Width of a word address on the Wishbone side and on the UI
`define MPMC_ADDR_W 24
// One data word, also the UI data width
`define MPMC_DATA_W 32
// Words held in a port's read buffer line
`define MPMC_LINE_WORDS 4
// Last burst count of a line fetch, so a fetch runs 0 up to this value
`define MPMC_BURST_LEN 3
// Number of Wishbone ports sharing the UI
`define MPMC_NPORTS 2

// UI command codes as the controller core decodes app_cmd
`define MPMC_CMD_WRITE 3'b000
`define MPMC_CMD_READ 3'b001

`endif

// ==== verilog/mpmc_pkg.sv ====
`include "mpmc_consts.svh"
`default_nettype none

package mpmc_pkg;

	// Sequencer states, write path first and then the read path
	typedef enum logic [2:0] {
		IDLE,
		WRITE_DATA0,
		WRITE_DATA1,
		WRITE_DATA2,
		READ_DATA0,
		READ_DATA1,
		READ_DATA2,
		READ_WAIT
	} mpmc_state_t;

	// ========================================
	// Wishbone classic port signals
	// ========================================
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`MPMC_DATA_W/8-1:0] sel;
		logic [`MPMC_ADDR_W-1:0] adr;
		logic [`MPMC_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`MPMC_DATA_W-1:0] dat;
	} wb_rsp_t;

	// ========================================
	// Port to arbiter to sequencer
	// ========================================
	typedef struct packed {
		logic valid;
		logic we;
		logic [`MPMC_ADDR_W-1:0] adr;
		logic [`MPMC_DATA_W-1:0] dat;
		logic [`MPMC_DATA_W/8-1:0] sel;
	} mem_req_t;

	// Line is only meaningful when done ends a read
	typedef struct packed {
		logic done;
		logic [`MPMC_LINE_WORDS-1:0][`MPMC_DATA_W-1:0] line;
		logic inv;
		logic [`MPMC_ADDR_W-$clog2(`MPMC_LINE_WORDS)-1:0] inv_adr;
	} mem_rsp_t;

	// ========================================
	// Memory UI of the controller core
	// ========================================
	typedef struct packed {
		logic en;
		logic [2:0] cmd;
		logic [`MPMC_ADDR_W-1:0] addr;
	} ui_cmd_t;

	// The last flag drives app_wdf_end, every write here is a single beat
	typedef struct packed {
		logic wren;
		logic last;
		logic [`MPMC_DATA_W-1:0] data;
		logic [`MPMC_DATA_W/8-1:0] mask;
	} ui_wdf_t;

endpackage

`default_nettype wire

// ==== verilog/mpmc_read_line.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_read_line (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::wb_req_t wb_req,
	output mpmc_pkg::wb_rsp_t wb_rsp,
	output mpmc_pkg::mem_req_t mem_req,
	input  mpmc_pkg::mem_rsp_t mem_rsp,
	input  logic inv,
	input  logic [`MPMC_ADDR_W-$clog2(`MPMC_LINE_WORDS)-1:0] inv_adr
);

	localparam int OFF_W = $clog2(`MPMC_LINE_WORDS);

	// The buffered line with its tag
	logic [`MPMC_LINE_WORDS-1:0][`MPMC_DATA_W-1:0] line_q;
	logic [`MPMC_ADDR_W-OFF_W-1:0] tag_q;
	logic line_valid;

	logic req_q;
	logic ack_q;
	logic [`MPMC_DATA_W-1:0] rd_dat_q;

	logic [`MPMC_ADDR_W-OFF_W-1:0] req_tag;
	logic [OFF_W-1:0] req_off;
	logic active;
	logic inv_hit;
	logic hit;
	logic start;
	logic fill;

	assign req_tag = wb_req.adr[`MPMC_ADDR_W-1:OFF_W];
	assign req_off = wb_req.adr[OFF_W-1:0];

	// A strobe that is neither waiting on the sequencer nor in its ack cycle
	assign active = wb_req.cyc & wb_req.stb & ~req_q & ~ack_q;

	// A write landing on our line this cycle makes the buffer unusable now
	assign inv_hit = inv & (inv_adr == tag_q);
	assign hit = active & ~wb_req.we & line_valid & ~inv_hit & (req_tag == tag_q);

	// Misses and all writes go out through the arbiter
	assign start = active & ~hit;
	assign fill = req_q & mem_rsp.done & ~wb_req.we;

	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= 1'b0;
			req_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			// One-cycle ack after a hit or after the sequencer finishes
			ack_q <= hit | (req_q & mem_rsp.done);
			if (start)
				req_q <= 1'b1;
			else if (mem_rsp.done)
				req_q <= 1'b0;
			if (fill)
				line_valid <= 1'b1;
			// Placed last so an invalidate always wins, own writes included
			if (inv_hit)
				line_valid <= 1'b0;
		end
	end

	// Line storage and read data
	always_ff @(posedge clk) begin
		if (fill) begin
			line_q <= mem_rsp.line;
			tag_q <= req_tag;
		end
		if (hit)
			rd_dat_q <= line_q[req_off];
		else if (mem_rsp.done)
			rd_dat_q <= mem_rsp.line[req_off];
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = rd_dat_q;
		// The Wishbone master keeps these stable until ack, which comes after done
		mem_req.valid = req_q;
		mem_req.we = wb_req.we;
		mem_req.adr = wb_req.adr;
		mem_req.dat = wb_req.dat;
		mem_req.sel = wb_req.sel;
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_port_arbiter.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_port_arbiter (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::mem_req_t [`MPMC_NPORTS-1:0] port_req,
	output mpmc_pkg::mem_rsp_t [`MPMC_NPORTS-1:0] port_rsp,
	output mpmc_pkg::mem_req_t seq_req,
	input  mpmc_pkg::mem_rsp_t seq_rsp
);

	localparam int SEL_W = $clog2(`MPMC_NPORTS);

	logic lock;
	logic [SEL_W-1:0] grant;
	logic [SEL_W-1:0] rr_ptr;
	logic [SEL_W-1:0] pick;
	logic any_req;

	// Search from the round-robin pointer upward, the nearest requester wins
	always_comb begin : pick_next
		int idx;
		pick = rr_ptr;
		any_req = 1'b0;
		for (int i = `MPMC_NPORTS - 1; i >= 0; i--) begin
			idx = (int'(rr_ptr) + i) % `MPMC_NPORTS;
			if (port_req[idx].valid) begin
				pick = SEL_W'(idx);
				any_req = 1'b1;
			end
		end
	end

	// Grant is locked from the cycle after arbitration until done
	always_ff @(posedge clk) begin
		if (rst) begin
			lock <= 1'b0;
			grant <= '0;
			rr_ptr <= '0;
		end else if (lock) begin
			if (seq_rsp.done)
				lock <= 1'b0;
		end else if (any_req) begin
			lock <= 1'b1;
			grant <= pick;
			// The port just served goes to the back of the line
			rr_ptr <= SEL_W'((int'(pick) + 1) % `MPMC_NPORTS);
		end
	end

	always_comb begin
		seq_req = port_req[grant];
		seq_req.valid = lock & port_req[grant].valid;
	end

	// Completion goes to the granted port, invalidates go to everyone
	always_comb begin
		for (int i = 0; i < `MPMC_NPORTS; i++) begin
			port_rsp[i].done = seq_rsp.done & lock & (grant == SEL_W'(i));
			port_rsp[i].line = (grant == SEL_W'(i)) ? seq_rsp.line : '0;
			port_rsp[i].inv = seq_rsp.inv;
			port_rsp[i].inv_adr = seq_rsp.inv_adr;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_ui_sequencer.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_ui_sequencer (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::mem_req_t req,
	output mpmc_pkg::mem_rsp_t rsp,
	output mpmc_pkg::ui_cmd_t ui_cmd,
	output mpmc_pkg::ui_wdf_t ui_wdf,
	input  logic app_rdy,
	input  logic app_wdf_rdy,
	input  logic app_rd_data_valid,
	input  logic [`MPMC_DATA_W-1:0] app_rd_data
);

	localparam int OFF_W = $clog2(`MPMC_LINE_WORDS);

	mpmc_pkg::mpmc_state_t state;

	// One spare bit so both counters can reach a full line
	logic [OFF_W:0] burst_cnt;
	logic [OFF_W:0] word_cnt;

	logic [`MPMC_ADDR_W-1:0] cmd_addr;
	logic [`MPMC_DATA_W-1:0] wr_dat;
	logic [`MPMC_DATA_W/8-1:0] wr_sel;
	logic [`MPMC_LINE_WORDS-1:0][`MPMC_DATA_W-1:0] line_q;

	logic cmd_en;
	logic cmd_accept;
	logic wr_accept;
	logic last_word;

	// ========================================
	// Command enable
	// ========================================
	// A read command stays on the bus with en high until app_rdy takes it
	// A write also needs room in the data FIFO, so its en waits for both ready signals
	// and the command and its data go in together
	always_comb begin
		cmd_en = (state == mpmc_pkg::WRITE_DATA1 && app_rdy && app_wdf_rdy)
			|| (state == mpmc_pkg::READ_DATA0)
			|| (state == mpmc_pkg::READ_DATA2 && burst_cnt <= `MPMC_BURST_LEN);
	end

	assign cmd_accept = cmd_en & app_rdy;
	assign wr_accept = cmd_en & (state == mpmc_pkg::WRITE_DATA1);
	assign last_word = app_rd_data_valid && (word_cnt == `MPMC_LINE_WORDS - 1);

	// ========================================
	// State machine
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mpmc_pkg::IDLE;
			burst_cnt <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
			mpmc_pkg::IDLE:
				if (req.valid) begin
					burst_cnt <= '0;
					word_cnt <= '0;
					state <= req.we ? mpmc_pkg::WRITE_DATA0 : mpmc_pkg::READ_DATA0;
				end
			// Request registers are loaded, present them next
			mpmc_pkg::WRITE_DATA0:
				state <= mpmc_pkg::WRITE_DATA1;
			mpmc_pkg::WRITE_DATA1:
				if (cmd_en)
					state <= mpmc_pkg::WRITE_DATA2;
			// Turnaround so the arbiter drops the finished request first
			mpmc_pkg::WRITE_DATA2:
				state <= mpmc_pkg::IDLE;
			mpmc_pkg::READ_DATA0:
				if (cmd_accept) begin
					burst_cnt <= 1;
					state <= mpmc_pkg::READ_DATA2;
				end
			mpmc_pkg::READ_DATA2:
				if (cmd_accept) begin
					burst_cnt <= burst_cnt + 1'b1;
					if (burst_cnt == `MPMC_BURST_LEN)
						state <= mpmc_pkg::READ_WAIT;
				end
			// All commands are out, wait for the rest of the line
			mpmc_pkg::READ_WAIT:
				if (word_cnt == `MPMC_LINE_WORDS || last_word)
					state <= mpmc_pkg::READ_DATA1;
			// Line complete, done pulses here
			mpmc_pkg::READ_DATA1:
				state <= mpmc_pkg::IDLE;
			default:
				state <= mpmc_pkg::IDLE;
			endcase
			if (state != mpmc_pkg::IDLE && app_rd_data_valid)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	// Command payload and the line being assembled
	always_ff @(posedge clk) begin
		if (state == mpmc_pkg::IDLE && req.valid) begin
			// Reads always start at the line base
			cmd_addr <= req.we ? req.adr : {req.adr[`MPMC_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
			wr_dat <= req.dat;
			wr_sel <= req.sel;
		end else if (cmd_accept && !wr_accept) begin
			cmd_addr <= cmd_addr + 1'b1;
		end
		// Words return in command order
		if (app_rd_data_valid && word_cnt < `MPMC_LINE_WORDS)
			line_q[word_cnt[OFF_W-1:0]] <= app_rd_data;
	end

	// ========================================
	// Outputs
	// ========================================
	always_comb begin
		ui_cmd.en = cmd_en;
		ui_cmd.cmd = (state inside {mpmc_pkg::WRITE_DATA0, mpmc_pkg::WRITE_DATA1,
			mpmc_pkg::WRITE_DATA2}) ? `MPMC_CMD_WRITE : `MPMC_CMD_READ;
		ui_cmd.addr = cmd_addr;
		// Single-beat writes, so every beat is also the last
		ui_wdf.wren = wr_accept;
		ui_wdf.last = wr_accept;
		ui_wdf.data = wr_dat;
		ui_wdf.mask = ~wr_sel;
		rsp.done = wr_accept | (state == mpmc_pkg::READ_DATA1);
		rsp.line = line_q;
		rsp.inv = wr_accept;
		rsp.inv_adr = cmd_addr[`MPMC_ADDR_W-1:OFF_W];
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_top.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_top (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::wb_req_t [`MPMC_NPORTS-1:0] wb_req,
	output mpmc_pkg::wb_rsp_t [`MPMC_NPORTS-1:0] wb_rsp,
	output mpmc_pkg::ui_cmd_t ui_cmd,
	output mpmc_pkg::ui_wdf_t ui_wdf,
	input  logic app_rdy,
	input  logic app_wdf_rdy,
	input  logic app_rd_data_valid,
	input  logic [`MPMC_DATA_W-1:0] app_rd_data
);

	mpmc_pkg::mem_req_t [`MPMC_NPORTS-1:0] port_req;
	mpmc_pkg::mem_rsp_t [`MPMC_NPORTS-1:0] port_rsp;
	mpmc_pkg::mem_req_t seq_req;
	mpmc_pkg::mem_rsp_t seq_rsp;

	// One read buffer per Wishbone port
	for (genvar i = 0; i < `MPMC_NPORTS; i++) begin : g_port
		mpmc_read_line u_line (
			.clk(clk),
			.rst(rst),
			.wb_req(wb_req[i]),
			.wb_rsp(wb_rsp[i]),
			.mem_req(port_req[i]),
			.mem_rsp(port_rsp[i]),
			.inv(port_rsp[i].inv),
			.inv_adr(port_rsp[i].inv_adr)
		);
	end

	mpmc_port_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.port_req(port_req),
		.port_rsp(port_rsp),
		.seq_req(seq_req),
		.seq_rsp(seq_rsp)
	);

	// Only the sequencer talks to the controller core
	mpmc_ui_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.req(seq_req),
		.rsp(seq_rsp),
		.ui_cmd(ui_cmd),
		.ui_wdf(ui_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

endmodule

`default_nettype wire

// ==== test/mpmc_properties.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_properties (
	input logic clk,
	input logic rst,
	input mpmc_pkg::wb_req_t [`MPMC_NPORTS-1:0] wb_req,
	input mpmc_pkg::wb_rsp_t [`MPMC_NPORTS-1:0] wb_rsp,
	input mpmc_pkg::ui_cmd_t ui_cmd,
	input mpmc_pkg::ui_wdf_t ui_wdf,
	input logic app_rdy,
	input mpmc_pkg::mem_req_t seq_req,
	input mpmc_pkg::mem_rsp_t seq_rsp
);

	// Read by the testbench top at the end of the run
	int fail_count = 0;

	// A command the UI has not taken stays on the bus unchanged
	cmd_held: assert property (@(posedge clk) disable iff (rst)
		(ui_cmd.en && !app_rdy) |=> (ui_cmd.en && $stable(ui_cmd.cmd) && $stable(ui_cmd.addr)))
		else begin
			$error("UI command dropped or changed before app_rdy");
			fail_count++;
		end

	// Write data never goes out without its write command
	wren_with_cmd: assert property (@(posedge clk) disable iff (rst)
		ui_wdf.wren |-> (ui_cmd.en && ui_cmd.cmd == `MPMC_CMD_WRITE))
		else begin
			$error("app_wdf_wren without a write command");
			fail_count++;
		end

	for (genvar i = 0; i < `MPMC_NPORTS; i++) begin : g_port
		ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
			wb_rsp[i].ack |-> (wb_req[i].cyc && wb_req[i].stb))
			else begin
				$error("Wishbone ack outside of cyc and stb");
				fail_count++;
			end
	end

	// The sequencer only finishes a request that is still being presented
	done_with_valid: assert property (@(posedge clk) disable iff (rst)
		seq_rsp.done |-> seq_req.valid)
		else begin
			$error("Sequencer done without a valid request");
			fail_count++;
		end

endmodule

bind mpmc_top mpmc_properties props (
	.clk(clk),
	.rst(rst),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.ui_cmd(ui_cmd),
	.ui_wdf(ui_wdf),
	.app_rdy(app_rdy),
	.seq_req(seq_req),
	.seq_rsp(seq_rsp)
);

`default_nettype wire

// ==== test/mpmc_ui_model.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_ui_model (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::ui_cmd_t ui_cmd,
	input  mpmc_pkg::ui_wdf_t ui_wdf,
	output logic app_rdy,
	output logic app_wdf_rdy,
	output logic app_rd_data_valid,
	output logic [`MPMC_DATA_W-1:0] app_rd_data
);

	logic [`MPMC_DATA_W-1:0] mem [logic [`MPMC_ADDR_W-1:0]];
	logic [`MPMC_DATA_W-1:0] rd_fifo [$];
	int seed;
	int delay;

	// Unwritten locations read back a pattern built from the whole address
	function automatic logic [`MPMC_DATA_W-1:0] fill_word(input logic [`MPMC_ADDR_W-1:0] adr);
		return {adr[7:0], adr} ^ 32'h3c96a55a;
	endfunction

	initial begin
		seed = 32'hf6b3791f;
		delay = 0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
	end

	// Accepted commands are taken in the middle of the cycle where all is stable
	always @(negedge clk) begin
		logic [`MPMC_DATA_W-1:0] word;
		if (!rst && ui_cmd.en && app_rdy) begin
			word = mem.exists(ui_cmd.addr) ? mem[ui_cmd.addr] : fill_word(ui_cmd.addr);
			if (ui_cmd.cmd == `MPMC_CMD_READ)
				rd_fifo.push_back(word);
			else if (ui_wdf.wren) begin
				// A set mask bit keeps the old byte
				for (int b = 0; b < `MPMC_DATA_W / 8; b++)
					if (!ui_wdf.mask[b])
						word[8*b +: 8] = ui_wdf.data[8*b +: 8];
				mem[ui_cmd.addr] = word;
			end
		end
	end

	// Ready stalls about one cycle in four, read words come back in order
	always @(posedge clk) begin
		#1;
		app_rd_data_valid = 1'b0;
		if (rst) begin
			app_rdy = 1'b0;
			app_wdf_rdy = 1'b0;
			rd_fifo.delete();
		end else begin
			app_rdy = ($random(seed) & 3) != 0;
			app_wdf_rdy = ($random(seed) & 3) != 0;
			if (rd_fifo.size() == 0)
				delay = $random(seed) & 3;
			else if (delay > 0)
				delay = delay - 1;
			else begin
				app_rd_data_valid = 1'b1;
				app_rd_data = rd_fifo.pop_front();
				delay = $random(seed) & 3;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/mpmc_checker.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_checker (
	input  logic clk,
	input  logic rst,
	input  mpmc_pkg::wb_req_t [`MPMC_NPORTS-1:0] wb_req,
	input  mpmc_pkg::wb_rsp_t [`MPMC_NPORTS-1:0] wb_rsp,
	input  mpmc_pkg::ui_cmd_t ui_cmd,
	input  mpmc_pkg::ui_wdf_t ui_wdf,
	input  logic app_rdy,
	input  logic app_wdf_rdy,
	input  logic drain,
	output int errors,
	output int acks
);

	localparam int OFF_W = $clog2(`MPMC_LINE_WORDS);
	localparam int BEAT_W = 3 + `MPMC_ADDR_W + `MPMC_DATA_W + `MPMC_DATA_W / 8;

	logic [`MPMC_DATA_W-1:0] ref_mem [logic [`MPMC_ADDR_W-1:0]];
	logic [`MPMC_ADDR_W-1:0] rd_cmds [$];
	logic [BEAT_W-1:0] wr_beats [$];
	logic line_ok [`MPMC_NPORTS];
	logic [`MPMC_ADDR_W-OFF_W-1:0] line_tag [`MPMC_NPORTS];
	int wait_cnt [`MPMC_NPORTS];
	logic started;
	logic drained;

	initial begin
		errors = 0;
		acks = 0;
		drained = 1'b0;
	end

	function automatic logic [`MPMC_DATA_W-1:0] ref_word(input logic [`MPMC_ADDR_W-1:0] adr);
		if (ref_mem.exists(adr))
			return ref_mem[adr];
		return {adr[7:0], adr} ^ 32'h3c96a55a;
	endfunction

	task automatic value_error(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("ERROR %s got %h expected %h", name, got, want);
		errors++;
	endtask

	// ========================================
	// Wishbone completions
	// ========================================
	task automatic check_write(input int p);
		logic [BEAT_W-1:0] beat;
		logic [BEAT_W-1:0] want;
		logic [`MPMC_DATA_W-1:0] word;
		// Wren, wdf_end and app_wdf_rdy all come with the command, a set mask bit keeps a byte
		want = {3'b111, wb_req[p].adr, wb_req[p].dat, ~wb_req[p].sel};
		if (wr_beats.size() != 1) begin
			$display("Port %0d write acked with %0d UI writes pending", p, wr_beats.size());
			errors++;
		end else begin
			beat = wr_beats.pop_front();
			if (beat !== want)
				value_error($sformatf("ui_wdf and ui_cmd.addr of port %0d", p),
					64'(beat), 64'(want));
		end
		wr_beats.delete();
		word = ref_word(wb_req[p].adr);
		for (int b = 0; b < `MPMC_DATA_W / 8; b++)
			if (wb_req[p].sel[b])
				word[8*b +: 8] = wb_req[p].dat[8*b +: 8];
		ref_mem[wb_req[p].adr] = word;
		// Write-through drops the line from every port holding it
		for (int q = 0; q < `MPMC_NPORTS; q++)
			if (line_tag[q] == wb_req[p].adr[`MPMC_ADDR_W-1:OFF_W])
				line_ok[q] = 1'b0;
	endtask

	task automatic check_read(input int p);
		logic [`MPMC_ADDR_W-OFF_W-1:0] tag;
		logic [`MPMC_DATA_W-1:0] want;
		tag = wb_req[p].adr[`MPMC_ADDR_W-1:OFF_W];
		want = ref_word(wb_req[p].adr);
		if (wb_rsp[p].dat !== want)
			value_error($sformatf("wb_rsp[%0d].dat", p), 64'(wb_rsp[p].dat), 64'(want));
		if (line_ok[p] && line_tag[p] == tag) begin
			// A hit never reaches the arbiter, UI reads in flight belong to the other port
			if (wait_cnt[p] != 1) begin
				$display("Port %0d read hit acked %0d cycles after its strobe instead of one",
					p, wait_cnt[p]);
				errors++;
			end
		end else begin
			if (rd_cmds.size() != `MPMC_LINE_WORDS) begin
				$display("Port %0d read miss sent %0d UI reads instead of a line",
					p, rd_cmds.size());
				errors++;
			end else begin
				for (int i = 0; i < `MPMC_LINE_WORDS; i++)
					if (rd_cmds[i] !== {tag, OFF_W'(i)})
						value_error("ui_cmd.addr", 64'(rd_cmds[i]), 64'({tag, OFF_W'(i)}));
			end
			rd_cmds.delete();
		end
		line_ok[p] = 1'b1;
		line_tag[p] = tag;
	endtask

	// ========================================
	// Sampling in the middle of each cycle
	// ========================================
	always @(negedge clk) begin
		if (rst) begin
			started = 1'b0;
			rd_cmds.delete();
			wr_beats.delete();
			for (int p = 0; p < `MPMC_NPORTS; p++) begin
				line_ok[p] = 1'b0;
				wait_cnt[p] = 0;
			end
		end else begin
			// Acks first so a command accepted in this cycle belongs to the next one
			for (int p = 0; p < `MPMC_NPORTS; p++) begin
				if (wb_rsp[p].ack) begin
					acks++;
					if (wb_req[p].we)
						check_write(p);
					else
						check_read(p);
					wait_cnt[p] = 0;
				end else if (wb_req[p].cyc && wb_req[p].stb) begin
					wait_cnt[p]++;
				end
				if (wb_req[p].cyc)
					started = 1'b1;
			end
			if (ui_cmd.en && app_rdy) begin
				if (ui_cmd.cmd == `MPMC_CMD_WRITE)
					wr_beats.push_back({ui_wdf.wren, ui_wdf.last, app_wdf_rdy,
						ui_cmd.addr, ui_wdf.data, ui_wdf.mask});
				else
					rd_cmds.push_back(ui_cmd.addr);
			end
			if (!started && (ui_cmd.en || ui_wdf.wren || wb_rsp[0].ack || wb_rsp[1].ack)) begin
				$display("DUT output active before any Wishbone request");
				errors++;
			end
			// Nothing may be left over once both ports are finished
			if (drain && !drained) begin
				drained = 1'b1;
				if (rd_cmds.size() != 0 || wr_beats.size() != 0) begin
					$display("UI commands issued with no Wishbone transaction behind them");
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/mpmc_tb.sv ====
`include "mpmc_consts.svh"
`default_nettype none

module mpmc_tb;

	localparam int NTRANS = 80;
	localparam int ACK_TIMEOUT = 300;
	localparam int ADDR_W = `MPMC_ADDR_W;
	localparam int SEL_W = `MPMC_DATA_W / 8;
	// Four lines only, so hits and cross-port invalidation are frequent
	localparam logic [`MPMC_ADDR_W-1:0] ADDR_BASE = 24'h0a5c30;

	logic clk;
	logic rst;
	logic drain;
	mpmc_pkg::wb_req_t [`MPMC_NPORTS-1:0] wb_req;
	mpmc_pkg::wb_rsp_t [`MPMC_NPORTS-1:0] wb_rsp;
	mpmc_pkg::ui_cmd_t ui_cmd;
	mpmc_pkg::ui_wdf_t ui_wdf;
	logic app_rdy;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	logic [`MPMC_DATA_W-1:0] app_rd_data;
	int errors;
	int acks;
	int timeouts;
	int seed;
	mpmc_pkg::wb_req_t stim [`MPMC_NPORTS][NTRANS];

	mpmc_top uut (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ui_cmd(ui_cmd),
		.ui_wdf(ui_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

	mpmc_ui_model ui_model (
		.clk(clk),
		.rst(rst),
		.ui_cmd(ui_cmd),
		.ui_wdf(ui_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

	mpmc_checker chk (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ui_cmd(ui_cmd),
		.ui_wdf(ui_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.drain(drain),
		.errors(errors),
		.acks(acks)
	);

	always #50 clk = ~clk;

	// All transactions are drawn up front so the sequence never depends on thread order
	task automatic make_stimulus();
		for (int p = 0; p < `MPMC_NPORTS; p++) begin
			for (int n = 0; n < NTRANS; n++) begin
				stim[p][n].cyc = 1'b1;
				stim[p][n].stb = 1'b1;
				stim[p][n].we = ($random(seed) & 3) == 0;
				stim[p][n].adr = ADDR_BASE | ADDR_W'($random(seed) & 15);
				stim[p][n].dat = $random(seed);
				stim[p][n].sel = SEL_W'($random(seed));
				if (!stim[p][n].we || stim[p][n].sel == '0)
					stim[p][n].sel = '1;
			end
		end
	endtask

	// Back-to-back Wishbone cycles on one port, each ack awaited with a timeout
	task automatic run_port(input int p);
		int n;
		int wait_cycles;
		for (n = 0; n < NTRANS && timeouts == 0; n++) begin
			wb_req[p] = stim[p][n];
			wait_cycles = 0;
			@(negedge clk);
			while (!wb_rsp[p].ack && wait_cycles < ACK_TIMEOUT) begin
				@(negedge clk);
				wait_cycles++;
			end
			if (!wb_rsp[p].ack) begin
				$display("Port %0d got no ack for transaction %0d", p, n);
				timeouts++;
			end
			@(posedge clk);
			#1;
		end
		wb_req[p] = '0;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		drain = 1'b0;
		wb_req = '0;
		timeouts = 0;
		seed = 32'hf6b3791f;
		make_stimulus();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		// Idle cycles where the checker expects every output to stay low
		repeat (5) @(posedge clk);
		#1;
		fork
			run_port(0);
			run_port(1);
		join
		drain = 1'b1;
		repeat (3) @(posedge clk);
		$display("Acks %0d of %0d, errors %0d, assertion failures %0d, timeouts %0d",
			acks, 2 * NTRANS, errors, uut.props.fail_count, timeouts);
		if (errors == 0 && timeouts == 0 && uut.props.fail_count == 0 && acks == 2 * NTRANS)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/mpmc_pkg.sv
verilog/mpmc_read_line.sv
verilog/mpmc_port_arbiter.sv
verilog/mpmc_ui_sequencer.sv
verilog/mpmc_top.sv
test/mpmc_properties.sv
test/mpmc_ui_model.sv
test/mpmc_checker.sv
test/mpmc_tb.sv

// ==== Makefile ====
TOP = mpmc_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
